//--- rtl/serdbg_pkg.sv
package serdbg_pkg;

    ////////////////////
    // baud generation
    ////////////////////

    // housekeeping line, 16x tick from 82 in 1024 of ps_clk
    localparam logic [9:0] hsk_add = 10'd82;
    localparam int hsk_acc_bits = 10;

    // gps line at 38400 baud, 25 in 4096 of ps_clk
    localparam logic [11:0] gps_add = 12'd25;
    localparam int gps_acc_bits = 12;

    ////////////////////
    // frame format
    ////////////////////

    // ticks per bit time
    localparam int oversample = 16;

    // 8N1 frames, no parity
    localparam int data_bits = 8;

    // tag that marks which line a merged byte came from
    typedef enum logic {
        src_hsk = 1'b0,
        src_gps = 1'b1
    } src_t;

endpackage

//--- rtl/frac_baud_gen.sv
module frac_baud_gen #(
    parameter int unsigned inc = 82,
    parameter int acc_bits = 10
) (
    input  logic ps_clk,
    input  logic reset,
    output logic tick
);

    // the top bit holds the carry out of the previous add
    logic [acc_bits:0] acc;

    // the carry is dropped before each add, so it can only be high for one
    // cycle as long as inc stays below 2**acc_bits
    always_ff @(posedge ps_clk) begin
        if (reset) begin
            acc <= '0;
        end else begin
            acc <= {1'b0, acc[acc_bits-1:0]} + (acc_bits+1)'(inc);
        end
    end

    // average tick rate is ps_clk * inc / 2**acc_bits
    assign tick = acc[acc_bits];

endmodule

//--- rtl/uart_oversample_rx.sv
module uart_oversample_rx (
    input  logic                                ps_clk,
    input  logic                                reset,
    input  logic                                tick,
    input  logic                                rx,
    output logic                                byte_valid,
    output logic [serdbg_pkg::data_bits-1:0]    data,
    output logic                                frame_err
);

    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;

    logic [$clog2(serdbg_pkg::oversample)-1:0] tick_cnt;
    logic [$clog2(serdbg_pkg::data_bits)-1:0]  bit_cnt;

    logic fall;
    logic mid_start;
    logic bit_end;

    ////////////////////
    // line input
    ////////////////////

    // the line is asynchronous to ps_clk, and it idles high
    always_ff @(posedge ps_clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign fall = rx_prev && !rx_sync;

    // eighth tick after the edge lands mid start bit, sixteenth ends a bit time
    assign mid_start = tick && (tick_cnt == serdbg_pkg::oversample / 2 - 1);
    assign bit_end   = tick && (tick_cnt == serdbg_pkg::oversample - 1);

    ////////////////////
    // frame FSM
    ////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset) begin
            state      <= st_idle;
            tick_cnt   <= '0;
            bit_cnt    <= '0;
            byte_valid <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            if (tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            case (state)
                st_idle: begin
                    if (fall) begin
                        state    <= st_start;
                        tick_cnt <= '0;
                    end
                end
                st_start: begin
                    if (mid_start) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        // a start bit that is gone by mid bit was a glitch
                        if (rx_sync) begin
                            state <= st_idle;
                        end else begin
                            state <= st_data;
                        end
                    end
                end
                st_data: begin
                    if (bit_end) begin
                        tick_cnt <= '0;
                        if (bit_cnt == serdbg_pkg::data_bits - 1) begin
                            state <= st_stop;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                st_stop: begin
                    if (bit_end) begin
                        tick_cnt   <= '0;
                        byte_valid <= 1'b1;
                        state      <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    ////////////////////
    // payload
    ////////////////////

    // bits arrive LSB first, so shift in from the top
    always_ff @(posedge ps_clk) begin
        if (state == st_data && bit_end) begin
            data <= {rx_sync, data[serdbg_pkg::data_bits-1:1]};
        end
        if (state == st_stop && bit_end) begin
            frame_err <= !rx_sync;
        end
    end

endmodule

//--- rtl/serial_channel.sv
module serial_channel #(
    parameter int unsigned inc = 82,
    parameter int acc_bits = 10
) (
    input  logic                                ps_clk,
    input  logic                                reset,
    input  logic                                rx,
    input  logic                                take,
    output logic                                pending,
    output logic [serdbg_pkg::data_bits-1:0]    data,
    output logic                                frame_err,
    output logic                                overrun
);

    logic                               tick;
    logic                               byte_valid;
    logic [serdbg_pkg::data_bits-1:0]   rx_data;
    logic                               rx_ferr;
    logic                               accept;

    frac_baud_gen #(
        .inc      (inc),
        .acc_bits (acc_bits)
    ) u_baud (
        .ps_clk (ps_clk),
        .reset  (reset),
        .tick   (tick)
    );

    uart_oversample_rx u_rx (
        .ps_clk     (ps_clk),
        .reset      (reset),
        .tick       (tick),
        .rx         (rx),
        .byte_valid (byte_valid),
        .data       (rx_data),
        .frame_err  (rx_ferr)
    );

    // the merger copies the held byte in the same cycle it pulses take, so
    // a byte landing in that cycle can safely replace it
    assign accept = byte_valid && (!pending || take);

    always_ff @(posedge ps_clk) begin
        if (reset) begin
            pending <= 1'b0;
            overrun <= 1'b0;
        end else begin
            if (accept) begin
                pending <= 1'b1;
            end else if (take) begin
                pending <= 1'b0;
            end
            // the new byte is dropped and the loss is remembered until reset
            if (byte_valid && !accept) begin
                overrun <= 1'b1;
            end
        end
    end

    // one-byte holding register
    always_ff @(posedge ps_clk) begin
        if (accept) begin
            data      <= rx_data;
            frame_err <= rx_ferr;
        end
    end

endmodule

//--- rtl/byte_merger.sv
module byte_merger (
    input  logic                                ps_clk,
    input  logic                                reset,

    input  logic                                hsk_pending,
    input  logic [serdbg_pkg::data_bits-1:0]    hsk_data,
    input  logic                                hsk_ferr,
    output logic                                hsk_take,

    input  logic                                gps_pending,
    input  logic [serdbg_pkg::data_bits-1:0]    gps_data,
    input  logic                                gps_ferr,
    output logic                                gps_take,

    output logic                                out_req,
    input  logic                                out_ack,
    output logic [serdbg_pkg::data_bits-1:0]    out_data,
    output serdbg_pkg::src_t                    out_src,
    output logic                                out_ferr
);

    typedef enum logic [1:0] {
        st_idle,
        st_wait_ack_high,
        st_wait_ack_low
    } state_t;

    state_t           state;
    serdbg_pkg::src_t last_src;
    logic             pick_gps;
    logic             grant;

    ////////////////////
    // arbitration
    ////////////////////

    // with both lines pending the one served less recently wins
    always_comb begin
        if (hsk_pending && gps_pending) begin
            pick_gps = (last_src == serdbg_pkg::src_hsk);
        end else begin
            pick_gps = gps_pending;
        end
    end

    // a new request only starts once the consumer has let go of ack
    assign grant = (state == st_idle) && !out_ack && (hsk_pending || gps_pending);

    ////////////////////
    // four-phase port
    ////////////////////

    always_ff @(posedge ps_clk) begin
        if (reset) begin
            state    <= st_idle;
            out_req  <= 1'b0;
            hsk_take <= 1'b0;
            gps_take <= 1'b0;
            last_src <= serdbg_pkg::src_gps;
        end else begin
            hsk_take <= 1'b0;
            gps_take <= 1'b0;
            case (state)
                st_idle: begin
                    if (grant) begin
                        out_req  <= 1'b1;
                        hsk_take <= !pick_gps;
                        gps_take <= pick_gps;
                        last_src <= pick_gps ? serdbg_pkg::src_gps : serdbg_pkg::src_hsk;
                        state    <= st_wait_ack_high;
                    end
                end
                st_wait_ack_high: begin
                    if (out_ack) begin
                        out_req <= 1'b0;
                        state   <= st_wait_ack_low;
                    end
                end
                st_wait_ack_low: begin
                    if (!out_ack) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state   <= st_idle;
                    out_req <= 1'b0;
                end
            endcase
        end
    end

    // output registers only load on a grant, so they hold while out_req is up
    always_ff @(posedge ps_clk) begin
        if (grant) begin
            if (pick_gps) begin
                out_data <= gps_data;
                out_src  <= serdbg_pkg::src_gps;
                out_ferr <= gps_ferr;
            end else begin
                out_data <= hsk_data;
                out_src  <= serdbg_pkg::src_hsk;
                out_ferr <= hsk_ferr;
            end
        end
    end

endmodule

//--- rtl/serdbg_top.sv
module serdbg_top (
    input  logic                                ps_clk,
    input  logic                                reset,
    input  logic                                hsk_rx,
    input  logic                                gps_rx,
    output logic                                out_req,
    input  logic                                out_ack,
    output logic [serdbg_pkg::data_bits-1:0]    out_data,
    output serdbg_pkg::src_t                    out_src,
    output logic                                out_ferr,
    output logic                                hsk_overrun,
    output logic                                gps_overrun
);

    logic                               hsk_pending;
    logic [serdbg_pkg::data_bits-1:0]   hsk_data;
    logic                               hsk_ferr;
    logic                               hsk_take;

    logic                               gps_pending;
    logic [serdbg_pkg::data_bits-1:0]   gps_data;
    logic                               gps_ferr;
    logic                               gps_take;

    ////////////////////
    // receive channels
    ////////////////////

    serial_channel #(
        .inc      (serdbg_pkg::hsk_add),
        .acc_bits (serdbg_pkg::hsk_acc_bits)
    ) u_hsk_chan (
        .ps_clk    (ps_clk),
        .reset     (reset),
        .rx        (hsk_rx),
        .take      (hsk_take),
        .pending   (hsk_pending),
        .data      (hsk_data),
        .frame_err (hsk_ferr),
        .overrun   (hsk_overrun)
    );

    serial_channel #(
        .inc      (serdbg_pkg::gps_add),
        .acc_bits (serdbg_pkg::gps_acc_bits)
    ) u_gps_chan (
        .ps_clk    (ps_clk),
        .reset     (reset),
        .rx        (gps_rx),
        .take      (gps_take),
        .pending   (gps_pending),
        .data      (gps_data),
        .frame_err (gps_ferr),
        .overrun   (gps_overrun)
    );

    ////////////////////
    // merged output
    ////////////////////

    byte_merger u_merger (
        .ps_clk      (ps_clk),
        .reset       (reset),
        .hsk_pending (hsk_pending),
        .hsk_data    (hsk_data),
        .hsk_ferr    (hsk_ferr),
        .hsk_take    (hsk_take),
        .gps_pending (gps_pending),
        .gps_data    (gps_data),
        .gps_ferr    (gps_ferr),
        .gps_take    (gps_take),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .out_src     (out_src),
        .out_ferr    (out_ferr)
    );

endmodule

//--- test/clk_gen.sv
module clk_gen #(
    parameter int period       = 4,
    parameter int reset_cycles = 4
) (
    output logic ps_clk,
    output logic reset
);

    initial begin
        ps_clk = 1'b0;
        forever #(period / 2) ps_clk = ~ps_clk;
    end

    // reset drops just after a rising edge, like every other input
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge ps_clk);
        #1;
        reset = 1'b0;
    end

endmodule

//--- test/serdbg_tb.sv
module serdbg_tb;

    localparam int max_stim = 16;
    localparam int lfsr_seed = 77067;
    localparam int idle_clocks = 300;
    localparam int drain_clocks = 3000;
    localparam logic [15:0] rand_delay = 16'hffff;

    typedef struct packed {
        logic [15:0]                       delay;
        logic                              ferr;
        logic [serdbg_pkg::data_bits-1:0]  data;
    } exp_t;

    logic                              ps_clk;
    logic                              reset;
    logic                              hsk_rx;
    logic                              gps_rx;
    logic                              out_req;
    logic                              out_ack;
    logic [serdbg_pkg::data_bits-1:0]  out_data;
    serdbg_pkg::src_t                  out_src;
    logic                              out_ferr;
    logic                              hsk_overrun;
    logic                              gps_overrun;

    // stimulus table with one row per frame
    serdbg_pkg::src_t                  stim_line   [max_stim];
    logic [serdbg_pkg::data_bits-1:0]  stim_byte   [max_stim];
    logic                              stim_rand   [max_stim];
    logic                              stim_bad    [max_stim];
    logic                              stim_lost   [max_stim];
    int                                stim_offset [max_stim];
    logic [15:0]                       stim_delay  [max_stim];
    int                                n_stim;

    exp_t        hsk_exp_q[$];
    exp_t        gps_exp_q[$];
    logic [15:0] lfsr_state;

    clk_gen u_clk (
        .ps_clk (ps_clk),
        .reset  (reset)
    );

    serdbg_top dut (
        .ps_clk      (ps_clk),
        .reset       (reset),
        .hsk_rx      (hsk_rx),
        .gps_rx      (gps_rx),
        .out_req     (out_req),
        .out_ack     (out_ack),
        .out_data    (out_data),
        .out_src     (out_src),
        .out_ferr    (out_ferr),
        .hsk_overrun (hsk_overrun),
        .gps_overrun (gps_overrun)
    );

    ////////////////////
    // helpers
    ////////////////////

    task automatic report_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // the taps follow x^16 + x^14 + x^13 + x^11 + 1 and the register steps once per bit
    function automatic logic [15:0] lfsr_take(input int n);
        logic [15:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v = {v[14:0], fb};
        end
        return v;
    endfunction

    // clocks per bit is 16 * 2**acc_bits / inc
    function automatic real bit_clocks(input serdbg_pkg::src_t src);
        if (src == serdbg_pkg::src_hsk) begin
            return real'(serdbg_pkg::oversample) * (2.0 ** serdbg_pkg::hsk_acc_bits)
                / real'(serdbg_pkg::hsk_add);
        end
        return real'(serdbg_pkg::oversample) * (2.0 ** serdbg_pkg::gps_acc_bits)
            / real'(serdbg_pkg::gps_add);
    endfunction

    task automatic add_entry(input serdbg_pkg::src_t line, input logic [7:0] data,
                             input logic use_rand, input logic bad_stop, input logic lost,
                             input int offset, input logic [15:0] delay);
        stim_line[n_stim]   = line;
        stim_byte[n_stim]   = data;
        stim_rand[n_stim]   = use_rand;
        stim_bad[n_stim]    = bad_stop;
        stim_lost[n_stim]   = lost;
        stim_offset[n_stim] = offset;
        stim_delay[n_stim]  = delay;
        n_stim++;
    endtask

    // line, byte, random byte, bad stop, lost, offset in clocks, ack delay
    task automatic load_table();
        n_stim = 0;
        add_entry(serdbg_pkg::src_hsk, 8'h55, 1'b0, 1'b0, 1'b0, 10, 16'd0);
        add_entry(serdbg_pkg::src_hsk, 8'ha3, 1'b0, 1'b0, 1'b0, 0, 16'd3);
        add_entry(serdbg_pkg::src_hsk, 8'h00, 1'b1, 1'b0, 1'b0, 40, rand_delay);
        add_entry(serdbg_pkg::src_hsk, 8'h00, 1'b1, 1'b0, 1'b0, 0, rand_delay);
        add_entry(serdbg_pkg::src_hsk, 8'h0f, 1'b0, 1'b1, 1'b0, 500, 16'd5);
        add_entry(serdbg_pkg::src_hsk, 8'hff, 1'b0, 1'b0, 1'b0, 20, 16'd1);
        add_entry(serdbg_pkg::src_hsk, 8'h00, 1'b1, 1'b0, 1'b0, 9000, rand_delay);
        // the overrun burst comes long after the gps traffic has finished
        add_entry(serdbg_pkg::src_hsk, 8'h3c, 1'b0, 1'b0, 1'b0, 100000, 16'd6000);
        add_entry(serdbg_pkg::src_hsk, 8'hc3, 1'b0, 1'b0, 1'b0, 0, 16'd2);
        add_entry(serdbg_pkg::src_hsk, 8'h99, 1'b0, 1'b0, 1'b1, 0, 16'd0);
        add_entry(serdbg_pkg::src_gps, 8'h24, 1'b0, 1'b0, 1'b0, 100, 16'd2);
        add_entry(serdbg_pkg::src_gps, 8'h00, 1'b1, 1'b0, 1'b0, 0, rand_delay);
        add_entry(serdbg_pkg::src_gps, 8'h0a, 1'b0, 1'b1, 1'b0, 300, 16'd4);
        add_entry(serdbg_pkg::src_gps, 8'h47, 1'b0, 1'b0, 1'b0, 50, 16'd0);
    endtask

    ////////////////////
    // line drivers
    ////////////////////

    // every wait ends 1 time unit after a rising edge
    task automatic wait_clocks(input int n);
        repeat (n) begin
            @(posedge ps_clk);
            #1;
        end
    endtask

    task automatic set_line(input serdbg_pkg::src_t src, input logic v);
        if (src == serdbg_pkg::src_hsk) begin
            hsk_rx = v;
        end else begin
            gps_rx = v;
        end
    endtask

    task automatic send_frame(input serdbg_pkg::src_t src, input logic [7:0] data,
                              input logic bad_stop);
        logic [serdbg_pkg::data_bits+1:0] frame;
        real                              bit_t;
        real                              t_run;
        int                               pos;
        int                               target;
        frame = {!bad_stop, data, 1'b0};
        bit_t = bit_clocks(src);
        t_run = 0.0;
        pos = 0;
        // bit edges come from a running real time rounded to whole clocks
        for (int k = 0; k < serdbg_pkg::data_bits + 2; k++) begin
            set_line(src, frame[k]);
            t_run = t_run + bit_t;
            target = $rtoi(t_run + 0.5);
            wait_clocks(target - pos);
            pos = target;
        end
        set_line(src, 1'b1);
    endtask

    task automatic drive_line(input serdbg_pkg::src_t src);
        exp_t e;
        wait_clocks(1);
        for (int i = 0; i < n_stim; i++) begin
            if (stim_line[i] == src) begin
                wait_clocks(stim_offset[i]);
                e.data  = stim_byte[i];
                e.ferr  = stim_bad[i];
                e.delay = stim_delay[i];
                if (!stim_lost[i] && src == serdbg_pkg::src_hsk) begin
                    hsk_exp_q.push_back(e);
                end else if (!stim_lost[i]) begin
                    gps_exp_q.push_back(e);
                end
                send_frame(src, stim_byte[i], stim_bad[i]);
            end
        end
    endtask

    ////////////////////
    // checkers
    ////////////////////

    task automatic check_byte(input serdbg_pkg::src_t src,
                              input logic [serdbg_pkg::data_bits-1:0] data,
                              input logic ferr, output logic [15:0] ack_delay);
        exp_t head;
        ack_delay = '0;
        if ((src == serdbg_pkg::src_hsk && hsk_exp_q.size() == 0) ||
            (src == serdbg_pkg::src_gps && gps_exp_q.size() == 0)) begin
            report_error($sformatf("%s byte %02h arrived with none expected", src.name(), data));
        end else begin
            head = (src == serdbg_pkg::src_hsk) ? hsk_exp_q.pop_front() : gps_exp_q.pop_front();
            if (data !== head.data || ferr !== head.ferr) begin
                report_error($sformatf("%s byte %02h ferr %b, expected %02h ferr %b",
                    src.name(), data, ferr, head.data, head.ferr));
            end
            ack_delay = head.delay;
        end
    endtask

    task automatic check_stable(input serdbg_pkg::src_t src,
                                input logic [serdbg_pkg::data_bits-1:0] data, input logic ferr);
        if (out_src !== src || out_data !== data || out_ferr !== ferr) begin
            report_error($sformatf("output changed under out_req, %s %02h %b became %s %02h %b",
                src.name(), data, ferr, out_src.name(), out_data, out_ferr));
        end
    endtask

    task automatic check_overrun(input logic hsk_exp, input logic gps_exp);
        if (hsk_overrun !== hsk_exp || gps_overrun !== gps_exp) begin
            report_error($sformatf("overrun flags hsk %b gps %b, expected %b %b",
                hsk_overrun, gps_overrun, hsk_exp, gps_exp));
        end
    endtask

    // consumer side of the four-phase port that samples at the falling edge
    initial begin : ack_responder
        serdbg_pkg::src_t                  snap_src;
        logic [serdbg_pkg::data_bits-1:0]  snap_data;
        logic                              snap_ferr;
        logic [15:0]                       delay;
        out_ack = 1'b0;
        @(negedge reset);
        forever begin
            @(negedge ps_clk);
            if (out_req) begin
                snap_src  = out_src;
                snap_data = out_data;
                snap_ferr = out_ferr;
                check_byte(snap_src, snap_data, snap_ferr, delay);
                if (delay == rand_delay) begin
                    delay = lfsr_take(4);
                end
                repeat (delay) begin
                    @(negedge ps_clk);
                    if (!out_req) begin
                        report_error("out_req dropped before out_ack rose");
                    end
                    check_stable(snap_src, snap_data, snap_ferr);
                end
                @(posedge ps_clk);
                #1;
                out_ack = 1'b1;
                @(negedge ps_clk);
                while (out_req) begin
                    check_stable(snap_src, snap_data, snap_ferr);
                    @(negedge ps_clk);
                end
                // ack is held a little longer and no new request may start meanwhile
                repeat (2) begin
                    @(negedge ps_clk);
                    if (out_req) begin
                        report_error("out_req rose again while out_ack was high");
                    end
                end
                @(posedge ps_clk);
                #1;
                out_ack = 1'b0;
            end
        end
    end

    // upper bound on the run with every frame and ack taken one after another
    function automatic longint run_limit();
        real clocks;
        clocks = real'(idle_clocks + drain_clocks + 2000);
        for (int i = 0; i < n_stim; i++) begin
            clocks = clocks + stim_offset[i] + 10.0 * bit_clocks(stim_line[i]) + 20.0;
            clocks = clocks + ((stim_delay[i] == rand_delay) ? 15.0 : real'(stim_delay[i]));
        end
        return longint'(clocks) * 4;
    endfunction

    task automatic watchdog(input longint limit);
        #(limit);
        $display("timeout: the run did not finish within %0d time units", limit);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog expired");
    endtask

    ////////////////////
    // main sequence
    ////////////////////

    initial begin : main
        logic        hsk_lost;
        logic        gps_lost;
        logic [15:0] rand_bits;
        hsk_rx = 1'b1;
        gps_rx = 1'b1;
        lfsr_state = lfsr_seed[15:0];
        load_table();
        hsk_lost = 1'b0;
        gps_lost = 1'b0;
        for (int i = 0; i < n_stim; i++) begin
            if (stim_rand[i]) begin
                rand_bits = lfsr_take(serdbg_pkg::data_bits);
                stim_byte[i] = rand_bits[serdbg_pkg::data_bits-1:0];
            end
            if (stim_lost[i] && stim_line[i] == serdbg_pkg::src_hsk) begin
                hsk_lost = 1'b1;
            end
            if (stim_lost[i] && stim_line[i] == serdbg_pkg::src_gps) begin
                gps_lost = 1'b1;
            end
        end
        fork
            watchdog(run_limit());
        join_none
        @(negedge reset);
        check_overrun(1'b0, 1'b0);
        repeat (idle_clocks) begin
            @(negedge ps_clk);
            if (out_req) begin
                report_error("out_req rose with both lines idle");
            end
        end
        fork
            drive_line(serdbg_pkg::src_hsk);
            drive_line(serdbg_pkg::src_gps);
        join
        while (hsk_exp_q.size() != 0 || gps_exp_q.size() != 0 || out_req || out_ack) begin
            @(negedge ps_clk);
        end
        // a dropped byte must not turn up late
        repeat (drain_clocks) @(negedge ps_clk);
        check_overrun(hsk_lost, gps_lost);
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- serdbg_top.f
rtl/serdbg_pkg.sv
rtl/frac_baud_gen.sv
rtl/uart_oversample_rx.sv
rtl/serial_channel.sv
rtl/byte_merger.sv
rtl/serdbg_top.sv
test/clk_gen.sv
test/serdbg_tb.sv
